// ==== logic/vld_cfg_pkg.sv ====
// ==========================================================================
// Default sizes of the vector load engine and the ticket layout
// ==========================================================================

package vld_cfg_pkg;

    // Default geometry, read by the top level and the testbench
    localparam int DEF_VECTOR_LANES     = 8;
    localparam int DEF_VECTOR_REGISTERS = 32;
    localparam int DEF_DATA_WIDTH       = 32;
    localparam int DEF_ADDR_WIDTH       = 32;

    // Row bit sits directly above the lane index
    // The ticket is therefore one bit wider than the lane index
    function automatic int ticket_w(input int lanes);
        return $clog2(lanes) + 1;
    endfunction

endpackage

// ==== logic/vld_op_pkg.sv ====
// ==========================================================================
// Memory-op codes and request generator states
// ==========================================================================

package vld_op_pkg;

    // Address stepping mode of a load
    typedef enum logic [0:0] {
        OP_UNIT_STRIDED = 1'b0,
        OP_STRIDED      = 1'b1
    } mem_op_e;

    // Request generator FSM
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_ISSUE    = 2'd1,
        ST_WAIT_ROW = 2'd2
    } req_state_e;

endpackage

// ==== logic/vld_req_gen.sv ====
// ==========================================================================
// Request generator: instruction capture, address and ticket generation,
// pending lane tracking and expansion over destination registers
// ==========================================================================

module vld_req_gen #(
    parameter int VECTOR_LANES     = 8,
    parameter int VECTOR_REGISTERS = 32,
    parameter int DATA_WIDTH       = 32,
    parameter int ADDR_WIDTH       = 32
) (
    input  logic                                                  clk_i,
    input  logic                                                  rstn_i,
    // Instruction
    input  logic                                                  valid_i,
    input  logic [ADDR_WIDTH-1:0]                                 base_addr_i,
    input  logic [ADDR_WIDTH-1:0]                                 stride_i,
    input  logic [$clog2(VECTOR_REGISTERS)+$clog2(VECTOR_LANES):0] vl_i,
    input  logic [$clog2(VECTOR_REGISTERS)+$clog2(VECTOR_LANES):0] maxvl_i,
    input  logic [$clog2(VECTOR_REGISTERS)-1:0]                   dst_i,
    input  vld_op_pkg::mem_op_e                                   mem_op_i,
    output logic                                                  ready_o,
    output logic                                                  busy_o,
    // Memory request
    input  logic                                                  grant_i,
    output logic                                                  req_en_o,
    output logic [ADDR_WIDTH-1:0]                                 req_addr_o,
    output logic [vld_cfg_pkg::ticket_w(VECTOR_LANES)-1:0]        req_ticket_o,
    // Row control towards the scratchpad
    input  logic [1:0]                                            row_busy_i,
    output logic                                                  row_open_o,
    output logic                                                  row_sel_o,
    output logic [$clog2(VECTOR_REGISTERS)-1:0]                   row_dst_o,
    output logic [VECTOR_LANES-1:0]                               row_mask_o
);

    localparam int LANE_W     = $clog2(VECTOR_LANES);
    localparam int REG_W      = $clog2(VECTOR_REGISTERS);
    localparam int EXP_W      = REG_W + 1;
    localparam int VL_W       = REG_W + LANE_W + 1;
    localparam int ELEM_BYTES = DATA_WIDTH / 8;

    vld_op_pkg::req_state_e state_q;
    vld_op_pkg::mem_op_e    op_q;

    logic                    accept;
    logic                    grant_ok;
    logic                    open_next;
    logic                    row_done;
    logic                    last_reg;
    logic [ADDR_WIDTH-1:0]   addr_q;
    logic [ADDR_WIDTH-1:0]   stride_q;
    logic [VL_W-1:0]         vl_q;
    logic [VL_W-1:0]         done_elems;
    logic [EXP_W-1:0]        max_exp_q;
    logic [EXP_W-1:0]        exp_q;
    logic [EXP_W-1:0]        exp_nxt;
    logic [REG_W-1:0]        dst_q;
    logic                    row_q;
    logic [LANE_W-1:0]       lane_q;
    logic [VECTOR_LANES-1:0] pending_q;

    // Low count lanes set, all lanes once count reaches VECTOR_LANES
    function automatic logic [VECTOR_LANES-1:0] lane_mask(input logic [VL_W-1:0] count);
        lane_mask = ~({VECTOR_LANES{1'b1}} << count);
    endfunction

    // ======================================================================
    // Control flow
    // ======================================================================
    assign ready_o  = (state_q == vld_op_pkg::ST_IDLE);
    assign busy_o   = ~ready_o;
    assign accept   = valid_i && ready_o;
    assign grant_ok = req_en_o && grant_i;

    // Elements covered once the current register is done
    assign exp_nxt    = exp_q + 1'b1;
    assign done_elems = {exp_nxt, {LANE_W{1'b0}}};
    assign last_reg   = (done_elems >= vl_q) || (exp_nxt >= max_exp_q);

    assign row_done  = (state_q == vld_op_pkg::ST_ISSUE) && (pending_q == '0);
    assign open_next = (state_q == vld_op_pkg::ST_WAIT_ROW) && !row_busy_i[~row_q];

    // Memory request from the current lane
    assign req_en_o     = (state_q == vld_op_pkg::ST_ISSUE) && pending_q[lane_q];
    assign req_addr_o   = addr_q;
    assign req_ticket_o = {row_q, lane_q};

    // Row 0 on a new instruction, the other row on expansion
    assign row_open_o = accept || open_next;
    assign row_sel_o  = accept ? 1'b0 : ~row_q;
    assign row_dst_o  = accept ? dst_i : dst_q + 1'b1;
    assign row_mask_o = accept ? lane_mask(vl_i) : lane_mask(vl_q - done_elems);

    // ======================================================================
    // FSM and lane walk
    // ======================================================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= vld_op_pkg::ST_IDLE;
            row_q     <= 1'b0;
            lane_q    <= '0;
            pending_q <= '0;
            exp_q     <= '0;
        end else begin
            case (state_q)
                vld_op_pkg::ST_IDLE: begin
                    if (accept) begin
                        state_q   <= vld_op_pkg::ST_ISSUE;
                        row_q     <= 1'b0;
                        lane_q    <= '0;
                        pending_q <= lane_mask(vl_i);
                        exp_q     <= '0;
                    end
                end
                vld_op_pkg::ST_ISSUE: begin
                    if (grant_ok) begin
                        pending_q[lane_q] <= 1'b0;
                        lane_q            <= lane_q + 1'b1;
                    end else if (row_done) begin
                        // Drain both rows before going idle
                        if (!last_reg) begin
                            state_q <= vld_op_pkg::ST_WAIT_ROW;
                        end else if (row_busy_i == '0) begin
                            state_q <= vld_op_pkg::ST_IDLE;
                        end
                    end
                end
                vld_op_pkg::ST_WAIT_ROW: begin
                    if (open_next) begin
                        state_q   <= vld_op_pkg::ST_ISSUE;
                        row_q     <= ~row_q;
                        lane_q    <= '0;
                        pending_q <= row_mask_o;
                        exp_q     <= exp_nxt;
                    end
                end
                default: state_q <= vld_op_pkg::ST_IDLE;
            endcase
        end
    end

    // Instruction operands and running address
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q    <= base_addr_i;
            stride_q  <= stride_i;
            op_q      <= mem_op_i;
            vl_q      <= vl_i;
            max_exp_q <= maxvl_i[VL_W-1:LANE_W];
            dst_q     <= dst_i;
        end else begin
            if (grant_ok) begin
                addr_q <= addr_q + ((op_q == vld_op_pkg::OP_STRIDED) ?
                                    stride_q : ADDR_WIDTH'(ELEM_BYTES));
            end
            if (open_next) begin
                dst_q <= dst_q + 1'b1;
            end
        end
    end

endmodule

// ==== logic/vld_row_buffer.sv ====
// ==========================================================================
// Two-row scratchpad with active and served masks per row
// ==========================================================================

module vld_row_buffer #(
    parameter int VECTOR_LANES     = 8,
    parameter int VECTOR_REGISTERS = 32,
    parameter int DATA_WIDTH       = 32
) (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    // Row open from the request generator
    input  logic                                           row_open_i,
    input  logic                                           row_sel_i,
    input  logic [$clog2(VECTOR_REGISTERS)-1:0]            row_dst_i,
    input  logic [VECTOR_LANES-1:0]                        row_mask_i,
    // Memory response
    input  logic                                           resp_valid_i,
    input  logic [vld_cfg_pkg::ticket_w(VECTOR_LANES)-1:0] resp_ticket_i,
    input  logic [DATA_WIDTH-1:0]                          resp_data_i,
    // Row status and release
    input  logic [1:0]                                     row_release_i,
    output logic [1:0]                                     row_busy_o,
    output logic [1:0]                                     row_full_o,
    output logic [VECTOR_LANES*DATA_WIDTH-1:0]             row0_data_o,
    output logic [VECTOR_LANES*DATA_WIDTH-1:0]             row1_data_o,
    output logic [VECTOR_LANES-1:0]                        row0_served_o,
    output logic [VECTOR_LANES-1:0]                        row1_served_o,
    output logic [$clog2(VECTOR_REGISTERS)-1:0]            row0_dst_o,
    output logic [$clog2(VECTOR_REGISTERS)-1:0]            row1_dst_o
);

    localparam int LANE_W = $clog2(VECTOR_LANES);
    localparam int REG_W  = $clog2(VECTOR_REGISTERS);

    logic [1:0][VECTOR_LANES-1:0][DATA_WIDTH-1:0] data_q;
    logic [1:0][VECTOR_LANES-1:0]                 active_q;
    logic [1:0][VECTOR_LANES-1:0]                 served_q;
    logic [1:0][REG_W-1:0]                        dst_q;
    logic                                         resp_row;
    logic [LANE_W-1:0]                            resp_lane;

    // Ticket fields
    assign resp_row  = resp_ticket_i[LANE_W];
    assign resp_lane = resp_ticket_i[LANE_W-1:0];

    for (genvar r = 0; r < 2; r++) begin : g_row_status
        assign row_busy_o[r] = |active_q[r];
        assign row_full_o[r] = |active_q[r] && (active_q[r] == served_q[r]);
    end

    // ======================================================================
    // Row masks
    // ======================================================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            active_q <= '0;
            served_q <= '0;
        end else begin
            for (int r = 0; r < 2; r++) begin
                if (row_open_i && (row_sel_i == 1'(r))) begin
                    active_q[r] <= row_mask_i;
                    served_q[r] <= '0;
                end else begin
                    if (row_release_i[r]) begin
                        active_q[r] <= '0;
                    end
                    if (resp_valid_i && (resp_row == 1'(r))) begin
                        served_q[r][resp_lane] <= 1'b1;
                    end
                end
            end
        end
    end

    // Element data and destination register
    always_ff @(posedge clk_i) begin
        if (resp_valid_i) begin
            data_q[resp_row][resp_lane] <= resp_data_i;
        end
        if (row_open_i) begin
            dst_q[row_sel_i] <= row_dst_i;
        end
    end

    assign row0_data_o   = data_q[0];
    assign row1_data_o   = data_q[1];
    assign row0_served_o = served_q[0];
    assign row1_served_o = served_q[1];
    assign row0_dst_o    = dst_q[0];
    assign row1_dst_o    = dst_q[1];

endmodule

// ==== logic/vld_writeback.sv ====
// ==========================================================================
// Writeback selector with register unlock and row release
// ==========================================================================

module vld_writeback #(
    parameter int VECTOR_LANES     = 8,
    parameter int VECTOR_REGISTERS = 32,
    parameter int DATA_WIDTH       = 32
) (
    input  logic [1:0]                               row_full_i,
    input  logic [VECTOR_LANES*DATA_WIDTH-1:0]       row0_data_i,
    input  logic [VECTOR_LANES*DATA_WIDTH-1:0]       row1_data_i,
    input  logic [VECTOR_LANES-1:0]                  row0_served_i,
    input  logic [VECTOR_LANES-1:0]                  row1_served_i,
    input  logic [$clog2(VECTOR_REGISTERS)-1:0]      row0_dst_i,
    input  logic [$clog2(VECTOR_REGISTERS)-1:0]      row1_dst_i,
    output logic [1:0]                               row_release_o,
    output logic                                     wrtbck_req_o,
    output logic [VECTOR_LANES-1:0]                  wrtbck_en_o,
    output logic [$clog2(VECTOR_REGISTERS)-1:0]      wrtbck_reg_o,
    output logic [VECTOR_LANES*DATA_WIDTH-1:0]       wrtbck_data_o,
    output logic                                     unlock_en_o,
    output logic [$clog2(VECTOR_REGISTERS)-1:0]      unlock_reg_o
);

    logic pick_row1;

    // Row 0 wins when both rows are full
    assign pick_row1     = ~row_full_i[0];
    assign wrtbck_req_o  = |row_full_i;
    assign row_release_o = {pick_row1 & row_full_i[1], row_full_i[0]};

    assign wrtbck_en_o   = !wrtbck_req_o ? '0 : (pick_row1 ? row1_served_i : row0_served_i);
    assign wrtbck_reg_o  = pick_row1 ? row1_dst_i : row0_dst_i;
    assign wrtbck_data_o = pick_row1 ? row1_data_i : row0_data_i;

    // Register is unlocked together with its writeback
    assign unlock_en_o  = wrtbck_req_o;
    assign unlock_reg_o = wrtbck_reg_o;

endmodule

// ==== logic/vld_load_engine.sv ====
// ==========================================================================
// Vector load engine top level
// ==========================================================================

module vld_load_engine #(
    parameter int VECTOR_LANES     = vld_cfg_pkg::DEF_VECTOR_LANES,
    parameter int VECTOR_REGISTERS = vld_cfg_pkg::DEF_VECTOR_REGISTERS,
    parameter int DATA_WIDTH       = vld_cfg_pkg::DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH       = vld_cfg_pkg::DEF_ADDR_WIDTH
) (
    input  logic                                                  clk_i,
    input  logic                                                  rstn_i,
    // Instruction
    input  logic                                                  valid_i,
    input  logic [ADDR_WIDTH-1:0]                                 base_addr_i,
    input  logic [ADDR_WIDTH-1:0]                                 stride_i,
    input  logic [$clog2(VECTOR_REGISTERS)+$clog2(VECTOR_LANES):0] vl_i,
    input  logic [$clog2(VECTOR_REGISTERS)+$clog2(VECTOR_LANES):0] maxvl_i,
    input  logic [$clog2(VECTOR_REGISTERS)-1:0]                   dst_i,
    input  vld_op_pkg::mem_op_e                                   mem_op_i,
    output logic                                                  ready_o,
    // Memory request and response
    output logic                                                  req_en_o,
    output logic [ADDR_WIDTH-1:0]                                 req_addr_o,
    output logic [vld_cfg_pkg::ticket_w(VECTOR_LANES)-1:0]        req_ticket_o,
    input  logic                                                  grant_i,
    input  logic                                                  resp_valid_i,
    input  logic [vld_cfg_pkg::ticket_w(VECTOR_LANES)-1:0]        resp_ticket_i,
    input  logic [DATA_WIDTH-1:0]                                 resp_data_i,
    // Register file writeback and unlock
    output logic                                                  wrtbck_req_o,
    output logic [VECTOR_LANES-1:0]                               wrtbck_en_o,
    output logic [$clog2(VECTOR_REGISTERS)-1:0]                   wrtbck_reg_o,
    output logic [VECTOR_LANES*DATA_WIDTH-1:0]                    wrtbck_data_o,
    output logic                                                  unlock_en_o,
    output logic [$clog2(VECTOR_REGISTERS)-1:0]                   unlock_reg_o,
    output logic                                                  busy_o
);

    localparam int REG_W = $clog2(VECTOR_REGISTERS);

    logic                               row_open;
    logic                               row_sel;
    logic [REG_W-1:0]                   row_dst;
    logic [VECTOR_LANES-1:0]            row_mask;
    logic [1:0]                         row_busy;
    logic [1:0]                         row_full;
    logic [1:0]                         row_release;
    logic [VECTOR_LANES*DATA_WIDTH-1:0] row0_data;
    logic [VECTOR_LANES*DATA_WIDTH-1:0] row1_data;
    logic [VECTOR_LANES-1:0]            row0_served;
    logic [VECTOR_LANES-1:0]            row1_served;
    logic [REG_W-1:0]                   row0_dst;
    logic [REG_W-1:0]                   row1_dst;

    vld_req_gen #(
        .VECTOR_LANES    (VECTOR_LANES),
        .VECTOR_REGISTERS(VECTOR_REGISTERS),
        .DATA_WIDTH      (DATA_WIDTH),
        .ADDR_WIDTH      (ADDR_WIDTH)
    ) u_req_gen (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .valid_i     (valid_i),
        .base_addr_i (base_addr_i),
        .stride_i    (stride_i),
        .vl_i        (vl_i),
        .maxvl_i     (maxvl_i),
        .dst_i       (dst_i),
        .mem_op_i    (mem_op_i),
        .ready_o     (ready_o),
        .busy_o      (busy_o),
        .grant_i     (grant_i),
        .req_en_o    (req_en_o),
        .req_addr_o  (req_addr_o),
        .req_ticket_o(req_ticket_o),
        .row_busy_i  (row_busy),
        .row_open_o  (row_open),
        .row_sel_o   (row_sel),
        .row_dst_o   (row_dst),
        .row_mask_o  (row_mask)
    );

    vld_row_buffer #(
        .VECTOR_LANES    (VECTOR_LANES),
        .VECTOR_REGISTERS(VECTOR_REGISTERS),
        .DATA_WIDTH      (DATA_WIDTH)
    ) u_row_buffer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .row_open_i   (row_open),
        .row_sel_i    (row_sel),
        .row_dst_i    (row_dst),
        .row_mask_i   (row_mask),
        .resp_valid_i (resp_valid_i),
        .resp_ticket_i(resp_ticket_i),
        .resp_data_i  (resp_data_i),
        .row_release_i(row_release),
        .row_busy_o   (row_busy),
        .row_full_o   (row_full),
        .row0_data_o  (row0_data),
        .row1_data_o  (row1_data),
        .row0_served_o(row0_served),
        .row1_served_o(row1_served),
        .row0_dst_o   (row0_dst),
        .row1_dst_o   (row1_dst)
    );

    vld_writeback #(
        .VECTOR_LANES    (VECTOR_LANES),
        .VECTOR_REGISTERS(VECTOR_REGISTERS),
        .DATA_WIDTH      (DATA_WIDTH)
    ) u_writeback (
        .row_full_i   (row_full),
        .row0_data_i  (row0_data),
        .row1_data_i  (row1_data),
        .row0_served_i(row0_served),
        .row1_served_i(row1_served),
        .row0_dst_i   (row0_dst),
        .row1_dst_i   (row1_dst),
        .row_release_o(row_release),
        .wrtbck_req_o (wrtbck_req_o),
        .wrtbck_en_o  (wrtbck_en_o),
        .wrtbck_reg_o (wrtbck_reg_o),
        .wrtbck_data_o(wrtbck_data_o),
        .unlock_en_o  (unlock_en_o),
        .unlock_reg_o (unlock_reg_o)
    );

endmodule

// ==== sim/vld_sva.sv ====
// ==========================================================================
// Protocol assertions for the vector load engine, bound to the top level
// ==========================================================================

module vld_sva #(
    parameter int DATA_W = 32,
    parameter int REG_W  = 5,
    parameter int ADDR_W = 32,
    parameter int TKT_W  = 4
) (
    input logic                clk_i,
    input logic                rstn_i,
    input logic                valid_i,
    input logic [ADDR_W-1:0]   stride_i,
    input vld_op_pkg::mem_op_e mem_op_i,
    input logic                ready_o,
    input logic                busy_o,
    input logic                req_en_o,
    input logic [ADDR_W-1:0]   req_addr_o,
    input logic [TKT_W-1:0]    req_ticket_o,
    input logic                grant_i,
    input logic                wrtbck_req_o,
    input logic [REG_W-1:0]    wrtbck_reg_o,
    input logic                unlock_en_o,
    input logic [REG_W-1:0]    unlock_reg_o
);

    logic              granted_q;
    logic [ADDR_W-1:0] step_q;
    logic [ADDR_W-1:0] next_addr_q;

    // First grant of an instruction has no predecessor
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            granted_q <= 1'b0;
        end else if (valid_i && ready_o) begin
            granted_q <= 1'b0;
        end else if (req_en_o && grant_i) begin
            granted_q <= 1'b1;
        end
    end

    // Address step of the accepted load and address due at the next grant
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            step_q <= (mem_op_i == vld_op_pkg::OP_STRIDED) ? stride_i : ADDR_W'(DATA_W / 8);
        end
        if (req_en_o && grant_i) begin
            next_addr_q <= req_addr_o + step_q;
        end
    end

    // Quiet outputs while reset is held
    a_reset_state: assert property (@(posedge clk_i)
        !rstn_i |-> ready_o && !req_en_o && !wrtbck_req_o && !unlock_en_o && !busy_o)
        else $error("outputs not in reset state");

    // Request held steady until granted
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_en_o && !grant_i |=> req_en_o && $stable(req_addr_o) && $stable(req_ticket_o))
        else $error("request changed without grant");

    // Consecutive granted addresses differ by one step
    a_stride: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_en_o && grant_i && granted_q |-> req_addr_o == next_addr_q)
        else $error("granted address does not follow the step");

    // Back-to-back writebacks only for two different registers
    a_wb_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wrtbck_req_o |=> !wrtbck_req_o || (wrtbck_reg_o != $past(wrtbck_reg_o)))
        else $error("writeback held for more than one cycle");

    a_unlock: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (unlock_en_o == wrtbck_req_o) && (!wrtbck_req_o || unlock_reg_o == wrtbck_reg_o))
        else $error("unlock does not follow writeback");

    a_ready_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ready_o == !busy_o) && (!wrtbck_req_o || busy_o))
        else $error("ready and busy disagree");

endmodule

bind vld_load_engine vld_sva #(
    .DATA_W(DATA_WIDTH),
    .REG_W ($clog2(VECTOR_REGISTERS)),
    .ADDR_W(ADDR_WIDTH),
    .TKT_W (vld_cfg_pkg::ticket_w(VECTOR_LANES))
) u_sva (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .valid_i     (valid_i),
    .stride_i    (stride_i),
    .mem_op_i    (mem_op_i),
    .ready_o     (ready_o),
    .busy_o      (busy_o),
    .req_en_o    (req_en_o),
    .req_addr_o  (req_addr_o),
    .req_ticket_o(req_ticket_o),
    .grant_i     (grant_i),
    .wrtbck_req_o(wrtbck_req_o),
    .wrtbck_reg_o(wrtbck_reg_o),
    .unlock_en_o (unlock_en_o),
    .unlock_reg_o(unlock_reg_o)
);

// ==== sim/tb_vld.sv ====
// ==========================================================================
// Testbench for the vector load engine: stimulus, memory model, checks
// ==========================================================================

module tb_vld;

    localparam int LANES  = vld_cfg_pkg::DEF_VECTOR_LANES;
    localparam int NREGS  = vld_cfg_pkg::DEF_VECTOR_REGISTERS;
    localparam int DW     = vld_cfg_pkg::DEF_DATA_WIDTH;
    localparam int AW     = vld_cfg_pkg::DEF_ADDR_WIDTH;
    localparam int REG_W  = $clog2(NREGS);
    localparam int LANE_W = $clog2(LANES);
    localparam int VL_W   = REG_W + $clog2(LANES) + 1;
    localparam int TKT_W  = vld_cfg_pkg::ticket_w(LANES);
    localparam int NTESTS = 4;

    // Test table: op, base, stride, vl, maxvl, dst
    localparam int T_OP[NTESTS]     = '{0, 1, 1, 0};
    localparam int T_BASE[NTESTS]   = '{32'h1000, 32'h2000, 32'h3000, 32'h4000};
    localparam int T_STRIDE[NTESTS] = '{0, 12, 64, 0};
    localparam int T_VL[NTESTS]     = '{5, 21, 40, 8};
    localparam int T_MAXVL[NTESTS]  = '{64, 256, 16, 256};
    localparam int T_DST[NTESTS]    = '{3, 10, 31, 0};

    logic clk_i, rstn_i, valid_i, ready_o, grant_i, resp_valid_i, busy_o;
    logic [AW-1:0] base_addr_i, stride_i, req_addr_o;
    logic [VL_W-1:0] vl_i, maxvl_i;
    logic [REG_W-1:0] dst_i, wrtbck_reg_o, unlock_reg_o;
    vld_op_pkg::mem_op_e mem_op_i;
    logic req_en_o, wrtbck_req_o, unlock_en_o;
    logic [TKT_W-1:0] req_ticket_o, resp_ticket_i;
    logic [DW-1:0] resp_data_i;
    logic [LANES-1:0] wrtbck_en_o;
    logic [LANES*DW-1:0] wrtbck_data_o;

    integer seed = 32'h9c6d;
    int errors, checks, cycles, grant_cnt, wb_cnt, cur_nregs, cur_vl, pick, k;
    int limit = 20 * total_elems() + 200;
    logic [AW-1:0] cur_base, cur_step;
    logic [REG_W-1:0] cur_dst;
    logic [NREGS-1:0] wb_seen;
    logic [TKT_W-1:0] pend_tkt[$];
    logic [AW-1:0] pend_addr[$];
    logic [LANES*DW-1:0] exp_data, cmp_mask;
    logic [LANES-1:0] exp_en;

    vld_load_engine DUT (.*);

    function automatic int regs_for(input int vl, input int maxvl);
        int by_vl;
        by_vl = (vl + LANES - 1) / LANES;
        return (by_vl < maxvl / LANES) ? by_vl : maxvl / LANES;
    endfunction

    function automatic int total_elems();
        int sum;
        int n;
        sum = 0;
        for (int t = 0; t < NTESTS; t++) begin
            n = regs_for(T_VL[t], T_MAXVL[t]) * LANES;
            sum += (T_VL[t] < n) ? T_VL[t] : n;
        end
        return sum;
    endfunction

    function automatic logic [AW-1:0] elem_addr(input int j);
        return cur_base + AW'(j) * cur_step;
    endfunction

    task automatic check_val(input string name, input logic [LANES*DW-1:0] got,
                             input logic [LANES*DW-1:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the engine did not finish", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ======================================================================
    // Memory model: random grants, responses in random order
    // ======================================================================
    always @(negedge clk_i) begin
        resp_valid_i = 1'b0;
        grant_i      = 1'b0;
        if (rstn_i) begin
            if (pend_tkt.size() > 0 && ($random(seed) & 1)) begin
                pick          = {$random(seed)} % pend_tkt.size();
                resp_ticket_i = pend_tkt[pick];
                resp_data_i   = pend_addr[pick] ^ 32'h5a5a_a5a5;
                resp_valid_i  = 1'b1;
                pend_tkt.delete(pick);
                pend_addr.delete(pick);
            end
            grant_i = ({$random(seed)} % 4) != 0;
            if (req_en_o && grant_i) begin
                k = grant_cnt / LANES;
                check_val("req_addr_o", req_addr_o, elem_addr(grant_cnt));
                check_val("req_ticket_o", req_ticket_o,
                          {k[0], LANE_W'(grant_cnt % LANES)});
                pend_tkt.push_back(req_ticket_o);
                pend_addr.push_back(req_addr_o);
                grant_cnt++;
            end
        end
    end

    // Writeback and unlock monitor
    always @(negedge clk_i) begin
        if (rstn_i && busy_o && ready_o) begin
            errors++;
            $display("ready is high while the engine is busy");
        end
        if (rstn_i && wrtbck_req_o) begin
            k = int'(REG_W'(wrtbck_reg_o - cur_dst));
            if (k >= cur_nregs || wb_seen[k]) begin
                errors++;
                $display("unexpected writeback to register %0d", wrtbck_reg_o);
            end else begin
                wb_seen[k] = 1'b1;
                wb_cnt++;
                exp_data = '0;
                cmp_mask = '0;
                for (int i = 0; i < LANES; i++) begin
                    exp_en[i] = (k * LANES + i) < cur_vl;
                    if (exp_en[i]) begin
                        exp_data[i*DW +: DW] = elem_addr(k * LANES + i) ^ 32'h5a5a_a5a5;
                        cmp_mask[i*DW +: DW] = '1;
                    end
                end
                check_val("wrtbck_en_o", wrtbck_en_o, exp_en);
                check_val("wrtbck_data_o", wrtbck_data_o & cmp_mask, exp_data);
                check_val("unlock_en_o", unlock_en_o, 1'b1);
                check_val("unlock_reg_o", unlock_reg_o, wrtbck_reg_o);
            end
        end
    end

    task automatic run_load(input int t);
        cur_base  = T_BASE[t];
        cur_step  = (T_OP[t] == 1) ? AW'(T_STRIDE[t]) : AW'(DW / 8);
        cur_vl    = T_VL[t];
        cur_dst   = T_DST[t];
        cur_nregs = regs_for(T_VL[t], T_MAXVL[t]);
        wb_seen   = '0;
        wb_cnt    = 0;
        grant_cnt = 0;
        @(negedge clk_i);
        base_addr_i = T_BASE[t];
        stride_i    = T_STRIDE[t];
        vl_i        = T_VL[t];
        maxvl_i     = T_MAXVL[t];
        dst_i       = T_DST[t];
        mem_op_i    = vld_op_pkg::mem_op_e'(T_OP[t]);
        valid_i     = 1'b1;
        @(negedge clk_i);
        valid_i = 1'b0;
        // Extra instruction while busy must be ignored
        if (t == NTESTS - 1) begin
            base_addr_i = 32'h9000;
            dst_i       = 20;
            valid_i     = 1'b1;
            @(negedge clk_i);
            @(negedge clk_i);
            valid_i = 1'b0;
        end
        while (busy_o) @(negedge clk_i);
        check_val("writeback count", wb_cnt, cur_nregs);
        check_val("grant count", grant_cnt, (cur_vl < cur_nregs * LANES) ?
                  cur_vl : cur_nregs * LANES);
        check_val("ready_o", ready_o, 1'b1);
    endtask

    initial begin
        rstn_i       = 1'b0;
        valid_i      = 1'b0;
        base_addr_i  = '0;
        stride_i     = '0;
        vl_i         = '0;
        maxvl_i      = '0;
        dst_i        = '0;
        mem_op_i     = vld_op_pkg::OP_UNIT_STRIDED;
        grant_i      = 1'b0;
        resp_valid_i = 1'b0;
        resp_ticket_i = '0;
        resp_data_i  = '0;
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;
        for (int t = 0; t < NTESTS; t++) begin
            run_load(t);
        end
        repeat (4) @(negedge clk_i);
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/vld_cfg_pkg.sv
logic/vld_op_pkg.sv
logic/vld_req_gen.sv
logic/vld_row_buffer.sv
logic/vld_writeback.sv
logic/vld_load_engine.sv
sim/vld_sva.sv
sim/tb_vld.sv

// ==== Makefile ====
VERILATOR ?= verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = tb_vld
FILELIST   = sim.f
LOG        = sim.log
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^sim passed$$" $(LOG); then \
		echo "result: PASS"; \
	else \
		echo "result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
